// File: design/hdc_pkg.sv
package hdc_pkg;

    // hypervector geometry
    localparam int hv_width   = 64;
    localparam int item_depth = 16;
    localparam int sym_bits   = 4;

    // position wraps modulo hv_width
    localparam int pos_bits  = 6;

    // distance spans 0 to hv_width inclusive
    localparam int dist_bits = 7;

    typedef logic [hv_width-1:0] hv_t;

    // operations issued from decode to execute
    typedef enum logic [2:0] {
        op_none,
        op_clear,
        op_item_wr,
        op_bind,
        op_finish,
        op_ref_wr
    } hv_op_e;

endpackage

// File: design/hdc_regs_pkg.sv
package hdc_regs_pkg;

    localparam int apb_addr_bits = 8;
    localparam int apb_data_bits = 32;

    // word offsets
    localparam logic [apb_addr_bits-1:0] reg_stage_lo = 8'h00;
    localparam logic [apb_addr_bits-1:0] reg_stage_hi = 8'h04;
    localparam logic [apb_addr_bits-1:0] reg_item     = 8'h08;
    localparam logic [apb_addr_bits-1:0] reg_ref      = 8'h0c;
    localparam logic [apb_addr_bits-1:0] reg_cmd      = 8'h10;
    localparam logic [apb_addr_bits-1:0] reg_status   = 8'h14;
    localparam logic [apb_addr_bits-1:0] reg_res_lo   = 8'h18;
    localparam logic [apb_addr_bits-1:0] reg_res_hi   = 8'h1c;
    localparam logic [apb_addr_bits-1:0] reg_dist     = 8'h20;

    // command register, bits 1:0
    localparam logic [1:0] cmd_clear  = 2'd1;
    localparam logic [1:0] cmd_bind   = 2'd2;
    localparam logic [1:0] cmd_finish = 2'd3;

    // symbol field in the command register
    localparam int cmd_sym_lsb = 4;

    // position field in the status register, done sits in bit 0
    localparam int status_pos_lsb = 8;

endpackage

// File: design/hv_op_if.sv
interface hv_op_if;
    import hdc_pkg::*;

    // single-cycle strobe, always accepted
    logic                op_valid;
    hv_op_e              op;
    logic [sym_bits-1:0] sym;
    // staging value
    hv_t                 data;

    modport issuer (
        output op_valid, op, sym, data
    );

    modport executor (
        input op_valid, op, sym, data
    );

endinterface

// File: design/hdc_cmd_decode.sv
module hdc_cmd_decode (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [hdc_regs_pkg::apb_addr_bits-1:0] paddr,
    input  logic [hdc_regs_pkg::apb_data_bits-1:0] pwdata,
    output logic [hdc_regs_pkg::apb_data_bits-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    hv_op_if.issuer                                op_port,
    input  logic [hdc_pkg::pos_bits-1:0]           cur_pos,
    input  hdc_pkg::hv_t                           res_hv,
    input  logic [hdc_pkg::dist_bits-1:0]          res_dist,
    input  logic                                   res_done
);
    import hdc_pkg::*;
    import hdc_regs_pkg::*;

    logic [apb_data_bits-1:0] stage_lo;
    logic [apb_data_bits-1:0] stage_hi;
    logic [apb_data_bits-1:0] status_word;
    logic                     access;
    logic                     wr_access;
    logic                     addr_mapped;
    logic                     addr_read_only;
    hv_op_e                   op_next;
    logic [sym_bits-1:0]      sym_next;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // zero wait states, execute never stalls
    assign pready  = 1'b1;
    assign pslverr = access && (!addr_mapped || (pwrite && addr_read_only));

    always_comb begin
        addr_mapped    = 1'b1;
        addr_read_only = 1'b0;
        case (paddr)
            reg_stage_lo, reg_stage_hi, reg_item, reg_ref, reg_cmd: addr_read_only = 1'b0;
            reg_status, reg_res_lo, reg_res_hi, reg_dist:           addr_read_only = 1'b1;
            default:                                                addr_mapped    = 1'b0;
        endcase
    end

    // staging halves of the next item or reference
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_lo <= '0;
            stage_hi <= '0;
        end else if (wr_access) begin
            if (paddr == reg_stage_lo) begin
                stage_lo <= pwdata;
            end
            if (paddr == reg_stage_hi) begin
                stage_hi <= pwdata;
            end
        end
    end

    // one operation per write access
    always_comb begin
        op_next  = op_none;
        sym_next = '0;
        if (wr_access) begin
            case (paddr)
                reg_item: begin
                    op_next  = op_item_wr;
                    sym_next = pwdata[sym_bits-1:0];
                end
                reg_ref: op_next = op_ref_wr;
                reg_cmd: begin
                    sym_next = pwdata[cmd_sym_lsb +: sym_bits];
                    case (pwdata[1:0])
                        cmd_clear:  op_next = op_clear;
                        cmd_bind:   op_next = op_bind;
                        cmd_finish: op_next = op_finish;
                        default:    op_next = op_none;
                    endcase
                end
                default: op_next = op_none;
            endcase
        end
    end

    assign op_port.op_valid = (op_next != op_none);
    assign op_port.op       = op_next;
    assign op_port.sym      = sym_next;
    assign op_port.data     = {stage_hi, stage_lo};

    always_comb begin
        status_word                               = '0;
        status_word[0]                            = res_done;
        status_word[status_pos_lsb +: pos_bits]   = cur_pos;
    end

    // write-only registers read back as zero
    always_comb begin
        case (paddr)
            reg_status:   prdata = status_word;
            reg_res_lo:   prdata = res_hv[apb_data_bits-1:0];
            reg_res_hi:   prdata = res_hv[hv_width-1:apb_data_bits];
            reg_dist:     prdata = {{(apb_data_bits-dist_bits){1'b0}}, res_dist};
            default:      prdata = '0;
        endcase
    end

endmodule

// File: design/hv_encode_unit.sv
module hv_encode_unit (
    input  logic                         clk,
    input  logic                         rst,
    hv_op_if.executor                    op_port,
    output logic                         enc_valid,
    output hdc_pkg::hv_t                 enc_hv,
    output logic                         ref_valid,
    output hdc_pkg::hv_t                 ref_hv,
    output logic [hdc_pkg::pos_bits-1:0] cur_pos,
    output logic                         clear
);
    import hdc_pkg::*;

    hv_t                 item_mem [item_depth];
    hv_t                 item_q;
    hv_t                 item_rot;
    hv_t                 acc_q;
    logic [pos_bits-1:0] pos_q;
    logic [pos_bits-1:0] item_pos_q;
    logic                bind_q;
    logic                fin_q;
    logic                do_clear;
    logic                do_item_wr;
    logic                do_bind;
    logic                do_finish;
    logic                do_ref_wr;

    assign do_clear   = op_port.op_valid && (op_port.op == op_clear);
    assign do_item_wr = op_port.op_valid && (op_port.op == op_item_wr);
    assign do_bind    = op_port.op_valid && (op_port.op == op_bind);
    assign do_finish  = op_port.op_valid && (op_port.op == op_finish);
    assign do_ref_wr  = op_port.op_valid && (op_port.op == op_ref_wr);

    always_ff @(posedge clk) begin
        if (do_item_wr) begin
            item_mem[op_port.sym] <= op_port.data;
        end
    end

    // bind stage 1: read the item and capture its position
    // a bind still in stage 2 has not bumped pos_q yet, so count it here
    always_ff @(posedge clk) begin
        if (do_bind) begin
            item_q     <= item_mem[op_port.sym];
            item_pos_q <= pos_q + pos_bits'(bind_q);
        end
    end

    // rotate right, low half of the doubled vector
    assign item_rot = hv_t'({item_q, item_q} >> item_pos_q);

    // bind stage 2 and the finish delay line
    always_ff @(posedge clk) begin
        if (rst) begin
            bind_q    <= 1'b0;
            fin_q     <= 1'b0;
            enc_valid <= 1'b0;
            ref_valid <= 1'b0;
            acc_q     <= '0;
            pos_q     <= '0;
        end else begin
            bind_q    <= do_bind;
            fin_q     <= do_finish;
            enc_valid <= fin_q;
            ref_valid <= do_ref_wr;
            if (do_clear) begin
                acc_q <= '0;
                pos_q <= '0;
            end else if (bind_q) begin
                acc_q <= acc_q ^ item_rot;
                pos_q <= pos_q + 1'b1;
            end
        end
    end

    // reference goes through to the result block
    always_ff @(posedge clk) begin
        if (do_ref_wr) begin
            ref_hv <= op_port.data;
        end
    end

    assign enc_hv  = acc_q;
    assign cur_pos = pos_q;
    assign clear   = do_clear;

endmodule

// File: design/hv_match_result.sv
module hv_match_result (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enc_valid,
    input  hdc_pkg::hv_t                  enc_hv,
    input  logic                          ref_valid,
    input  hdc_pkg::hv_t                  ref_hv,
    input  logic                          clear,
    output hdc_pkg::hv_t                  res_hv,
    output logic [hdc_pkg::dist_bits-1:0] res_dist,
    output logic                          res_done
);
    import hdc_pkg::*;

    hv_t                  ref_q;
    hv_t                  diff;
    logic [dist_bits-1:0] dist_next;

    assign diff = enc_hv ^ ref_q;

    // hamming distance as popcount of the difference
    always_comb begin
        dist_next = '0;
        for (int i = 0; i < hv_width; i++) begin
            dist_next = dist_next + {{(dist_bits-1){1'b0}}, diff[i]};
        end
    end

    // class reference
    always_ff @(posedge clk) begin
        if (rst) begin
            ref_q <= '0;
        end else if (ref_valid) begin
            ref_q <= ref_hv;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_hv   <= '0;
            res_dist <= '0;
        end else if (enc_valid) begin
            res_hv   <= enc_hv;
            res_dist <= dist_next;
        end
    end

    // done stays up until the next clear
    always_ff @(posedge clk) begin
        if (rst) begin
            res_done <= 1'b0;
        end else if (clear) begin
            res_done <= 1'b0;
        end else if (enc_valid) begin
            res_done <= 1'b1;
        end
    end

endmodule

// File: design/hdc_encoder_top.sv
module hdc_encoder_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [hdc_regs_pkg::apb_addr_bits-1:0] paddr,
    input  logic [hdc_regs_pkg::apb_data_bits-1:0] pwdata,
    output logic [hdc_regs_pkg::apb_data_bits-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr
);
    import hdc_pkg::*;

    logic                 enc_valid;
    hv_t                  enc_hv;
    logic                 ref_valid;
    hv_t                  ref_hv;
    logic                 enc_clear;
    logic [pos_bits-1:0]  cur_pos;
    hv_t                  res_hv;
    logic [dist_bits-1:0] res_dist;
    logic                 res_done;

    // decode to execute
    hv_op_if op_bus ();

    hdc_cmd_decode i_cmd_decode (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .op_port  (op_bus.issuer),
        .cur_pos  (cur_pos),
        .res_hv   (res_hv),
        .res_dist (res_dist),
        .res_done (res_done)
    );

    hv_encode_unit i_encode_unit (
        .clk       (clk),
        .rst       (rst),
        .op_port   (op_bus.executor),
        .enc_valid (enc_valid),
        .enc_hv    (enc_hv),
        .ref_valid (ref_valid),
        .ref_hv    (ref_hv),
        .cur_pos   (cur_pos),
        .clear     (enc_clear)
    );

    hv_match_result i_match_result (
        .clk       (clk),
        .rst       (rst),
        .enc_valid (enc_valid),
        .enc_hv    (enc_hv),
        .ref_valid (ref_valid),
        .ref_hv    (ref_hv),
        .clear     (enc_clear),
        .res_hv    (res_hv),
        .res_dist  (res_dist),
        .res_done  (res_done)
    );

endmodule

// File: testbench/hdc_encoder_chk.sv
module hdc_encoder_chk (
    input logic           clk,
    input logic           rst,
    input logic           psel,
    input logic           penable,
    input logic           pready,
    input logic           op_valid,
    input hdc_pkg::hv_op_e op,
    input logic           res_done
);
    timeunit 1ns;
    timeprecision 1ps;
    import hdc_pkg::*;

    int unsigned fail_count = 0;

    // slave never inserts wait states
    assert property (@(posedge clk) disable iff (rst) psel && penable |-> pready)
    else begin
        $error("pready low in an access phase");
        fail_count++;
    end

    // one operation per transfer
    assert property (@(posedge clk) disable iff (rst) op_valid |=> !op_valid)
    else begin
        $error("op_valid high for two cycles");
        fail_count++;
    end

    // a clear operation drops done at the next edge
    assert property (@(posedge clk) disable iff (rst)
                     op_valid && (op == op_clear) |=> !res_done)
    else begin
        $error("done still high after a clear");
        fail_count++;
    end

endmodule

bind hdc_encoder_top hdc_encoder_chk i_encoder_chk (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pready   (pready),
    .op_valid (op_bus.op_valid),
    .op       (op_bus.op),
    .res_done (res_done)
);

// File: testbench/hdc_scoreboard.sv
module hdc_scoreboard (
    input  logic                                   clk,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic                                   pready,
    input  logic [hdc_regs_pkg::apb_addr_bits-1:0] paddr,
    input  logic [hdc_regs_pkg::apb_data_bits-1:0] prdata,
    input  logic                                   pslverr,
    input  logic [hdc_regs_pkg::apb_data_bits-1:0] exp_data,
    input  logic                                   exp_err,
    input  int                                     test_id,
    input  logic                                   all_done,
    output int                                     tests_passed,
    output int                                     tests_failed
);
    timeunit 1ns;
    timeprecision 1ps;
    import hdc_regs_pkg::*;

    int   cur_test = 0;
    int   test_errors = 0;
    int   test_xfers = 0;
    logic closed = 1'b0;
    logic bad;

    function automatic string reg_name(input logic [apb_addr_bits-1:0] addr);
        case (addr)
            reg_stage_lo: return "stage_lo";
            reg_stage_hi: return "stage_hi";
            reg_item:     return "item";
            reg_ref:      return "ref";
            reg_cmd:      return "cmd";
            reg_status:   return "status";
            reg_res_lo:   return "res_lo";
            reg_res_hi:   return "res_hi";
            reg_dist:     return "dist";
            default:      return "unmapped";
        endcase
    endfunction

    task automatic close_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d transfers", cur_test, test_xfers);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d of %0d transfers wrong", cur_test, test_errors,
                     test_xfers);
        end
        test_errors = 0;
        test_xfers  = 0;
    endtask

    initial begin
        tests_passed = 0;
        tests_failed = 0;
    end

    // sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (psel && penable && pready) begin
            if (test_id != cur_test) begin
                if (cur_test != 0) begin
                    close_test();
                end
                cur_test = test_id;
            end
            test_xfers++;
            bad = 1'b0;
            if (pslverr !== exp_err) begin
                $display("error at %0d ns: pslverr on %s expected %0b, got %0b", $time,
                         reg_name(paddr), exp_err, pslverr);
                bad = 1'b1;
            end
            if (!pwrite && prdata !== exp_data) begin
                $display("error at %0d ns: prdata of %s expected %h, got %h", $time,
                         reg_name(paddr), exp_data, prdata);
                bad = 1'b1;
            end
            if (bad) begin
                test_errors++;
            end
        end else if (all_done && !closed) begin
            if (cur_test != 0) begin
                close_test();
            end
            closed = 1'b1;
        end
    end

endmodule

// File: testbench/tb_hdc_encoder.sv
module tb_hdc_encoder;
    timeunit 1ns;
    timeprecision 1ps;
    import hdc_regs_pkg::*;

    logic                     clk;
    logic                     rst;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apb_addr_bits-1:0] paddr;
    logic [apb_data_bits-1:0] pwdata;
    logic [apb_data_bits-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic [apb_data_bits-1:0] exp_data;
    logic                     exp_err;
    int                       test_id;
    logic                     all_done;
    int                       tests_passed;
    int                       tests_failed;
    logic [31:0]              rng;
    logic                     loaded;
    int                       n_vec;

    // one entry per transfer line of the input file
    int                       v_test[$];
    logic [7:0]               v_kind[$];
    logic [apb_addr_bits-1:0] v_addr[$];
    logic [apb_data_bits-1:0] v_data[$];
    logic                     v_err[$];

    hdc_encoder_top i_hdc_encoder_top (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    hdc_scoreboard i_scoreboard (
        .clk          (clk),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pready       (pready),
        .paddr        (paddr),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .exp_data     (exp_data),
        .exp_err      (exp_err),
        .test_id      (test_id),
        .all_done     (all_done),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic read_vectors(output int count);
        int                       fd;
        string                    line;
        int                       t;
        logic [7:0]               k;
        logic [apb_addr_bits-1:0] a;
        logic [apb_data_bits-1:0] d;
        int                       e;
        count = 0;
        fd = $fopen("testbench/hdc_input_vectors.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not scan
                if ($sscanf(line, "%d %s %h %h %d", t, k, a, d, e) == 5) begin
                    v_test.push_back(t);
                    v_kind.push_back(k);
                    v_addr.push_back(a);
                    v_data.push_back(d);
                    v_err.push_back(e[0]);
                    count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic apb_transfer(input int idx);
        psel     = 1'b1;
        penable  = 1'b0;
        pwrite   = (v_kind[idx] == "w");
        paddr    = v_addr[idx];
        pwdata   = pwrite ? v_data[idx] : '0;
        exp_data = v_data[idx];
        exp_err  = v_err[idx];
        test_id  = v_test[idx];
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        int unsigned asrt_fails;
        clk      = 1'b0;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        exp_data = '0;
        exp_err  = 1'b0;
        test_id  = 0;
        all_done = 1'b0;
        loaded   = 1'b0;
        rng      = 32'hfd0e;
        read_vectors(n_vec);
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (n_vec == 0) begin
            $display("no transfers could be read from testbench/hdc_input_vectors.txt");
            $display("Verification failed");
            $finish;
        end else begin
            for (int i = 0; i < n_vec; i++) begin
                apb_transfer(i);
                // 0 to 3 idle cycles
                rng = xorshift32(rng);
                repeat (rng % 4) begin
                    @(posedge clk);
                    #1;
                end
            end
            all_done = 1'b1;
            repeat (2) @(posedge clk);
            asrt_fails = i_hdc_encoder_top.i_encoder_chk.fail_count;
            $display("tests passed %0d, tests failed %0d, assertion failures %0d",
                     tests_passed, tests_failed, asrt_fails);
            if (tests_failed == 0 && asrt_fails == 0 && tests_passed > 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

    // at most 5 cycles per transfer, so 8 leaves margin
    initial begin
        wait (loaded);
        #(n_vec * 8 * 20 + 1000);
        $display("timeout: the transfer list did not complete in the allowed time");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: testbench/hdc_input_vectors.txt
# test  kind(w=write r=read)  addr(hex)  data or expected read data(hex)  pslverr
# item 5 = d1b54a329c7e0f68, item 6 = its complement, reference = item 5
1 r 14 00000000 0
1 r 18 00000000 0
1 r 20 00000000 0
2 w 00 9c7e0f68 0
2 w 04 d1b54a32 0
2 w 08 00000005 0
2 w 0c 00000000 0
2 w 00 6381f097 0
2 w 04 2e4ab5cd 0
2 w 08 00000006 0
2 w 10 00000001 0
2 w 10 00000052 0
2 w 10 00000003 0
2 r 08 00000000 0
2 r 14 00000101 0
2 r 18 9c7e0f68 0
2 r 20 00000000 0
3 w 10 00000001 0
3 w 10 00000052 0
3 w 10 00000052 0
3 w 10 00000062 0
3 w 10 00000052 0
3 w 10 00000062 0
3 w 10 00000003 0
3 r 08 00000000 0
3 r 14 00000501 0
3 r 18 0f16aa1d 0
3 r 1c 1a2f4042 0
3 r 20 0000001e 0
4 w 10 00000001 0
4 w 10 00000062 0
4 w 10 00000003 0
4 r 08 00000000 0
4 r 18 6381f097 0
4 r 20 00000040 0
5 w 10 00000001 0
5 r 14 00000000 0
5 w 10 00000052 0
5 w 10 00000003 0
5 r 08 00000000 0
5 r 14 00000101 0
5 r 18 9c7e0f68 0
6 w 14 00000001 1
6 w 18 12345678 1
6 w 20 00000000 1
6 w 40 00000000 1
6 r 40 00000000 1
6 r 14 00000101 0

// File: verilog.f
design/hdc_pkg.sv
design/hdc_regs_pkg.sv
design/hv_op_if.sv
design/hdc_cmd_decode.sv
design/hv_encode_unit.sv
design/hv_match_result.sv
design/hdc_encoder_top.sv
testbench/hdc_encoder_chk.sv
testbench/hdc_scoreboard.sv
testbench/tb_hdc_encoder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hdc_encoder
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
